/* common/cmul_pkg.sv */
package cmul_pkg;

  // Q1.15 sample format
  localparam int SAMPLE_W = 16;
  localparam int FRAC_W   = 15;

  // exact product is Q2.30, exact sum of two products is Q3.30
  localparam int PROD_W   = 2 * SAMPLE_W;
  localparam int SUM_W    = PROD_W + 1;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [SUM_W-1:0]    sum_t;

  // a1 sits in the low word, b2 in the high word
  typedef struct packed {
    sample_t b2;
    sample_t a2;
    sample_t b1;
    sample_t a1;
  } cmul_operands_t;

  typedef struct packed {
    sample_t im;
    sample_t re;
  } cplx_t;

  typedef struct packed {
    logic sat;      // a part was clipped
    logic inexact;  // a part lost nonzero fraction bits
  } cmul_status_t;

  // first stage products plus the operands still needed by the second stage
  typedef struct packed {
    prod_t   a1a2;
    prod_t   a1b2;
    sample_t b1;
    sample_t a2;
    sample_t b2;
  } prod_pipe_t;

endpackage

/* cmul/cmul_round_sat.sv */
`timescale 1ns/100ps

module cmul_round_sat (
  input  cmul_pkg::sum_t     sum_i,
  output cmul_pkg::sample_t  value_o,
  output logic               sat_o,
  output logic               inexact_o
);

  // kept part of the sum plus one bit of headroom for the round-up carry
  localparam int RND_W = cmul_pkg::SUM_W - cmul_pkg::FRAC_W + 1;

  logic             guard;
  logic             sticky;
  logic             lsb;
  logic             round_up;
  logic [RND_W-1:0] rounded;
  logic [RND_W-cmul_pkg::SAMPLE_W:0] top_bits;

  assign guard  = sum_i[cmul_pkg::FRAC_W-1];
  assign sticky = |sum_i[cmul_pkg::FRAC_W-2:0];
  assign lsb    = sum_i[cmul_pkg::FRAC_W];

  // nearest, ties to even; truncation of two's complement is a floor
  assign round_up = guard & (sticky | lsb);
  assign rounded  = {sum_i[cmul_pkg::SUM_W-1], sum_i[cmul_pkg::SUM_W-1:cmul_pkg::FRAC_W]}
                  + RND_W'(round_up);

  // fits in Q1.15 only when all bits above the sample are sign copies
  assign top_bits = rounded[RND_W-1:cmul_pkg::SAMPLE_W-1];
  assign sat_o    = ~((&top_bits) | ~(|top_bits));

  always_comb begin
    if (sat_o) begin
      value_o = {rounded[RND_W-1], {(cmul_pkg::SAMPLE_W-1){~rounded[RND_W-1]}}};
    end else begin
      value_o = rounded[cmul_pkg::SAMPLE_W-1:0];
    end
  end

  assign inexact_o = guard | sticky | sat_o;

endmodule

/* cmul/cmul_prod_stage.sv */
`timescale 1ns/100ps

module cmul_prod_stage (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       flush_i,
  // upstream
  input  cmul_pkg::cmul_operands_t   operands_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  // downstream
  output cmul_pkg::prod_pipe_t       pipe_o,
  output logic                       valid_o,
  input  logic                       ready_i,
  output logic                       busy_o
);

  logic                 valid_q;
  logic                 load;
  cmul_pkg::prod_pipe_t pipe_d;
  cmul_pkg::prod_pipe_t pipe_q;

  // accept when empty or when the content moves on this edge
  assign ready_o = ~flush_i & (~valid_q | ready_i);
  assign load    = valid_i & ready_o;

  // exact signed products, operands carried along for the second pass
  always_comb begin
    pipe_d.a1a2 = operands_i.a1 * operands_i.a2;
    pipe_d.a1b2 = operands_i.a1 * operands_i.b2;
    pipe_d.b1   = operands_i.b1;
    pipe_d.a2   = operands_i.a2;
    pipe_d.b2   = operands_i.b2;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      // item left and nothing replaced it
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      pipe_q <= pipe_d;
    end
  end

  assign pipe_o  = pipe_q;
  assign valid_o = valid_q;
  assign busy_o  = valid_q;

endmodule

/* cmul/cmul_macc_stage.sv */
`timescale 1ns/100ps

module cmul_macc_stage (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     flush_i,
  // from the product stage
  input  cmul_pkg::prod_pipe_t     pipe_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  // result side
  output cmul_pkg::cplx_t          result_o,
  output cmul_pkg::cmul_status_t   status_o,
  output logic                     valid_o,
  input  logic                     ready_i,
  output logic                     busy_o
);

  logic                          valid_q;
  logic                          load;

  // one extra bit so that negating -1.0 stays exact
  logic signed [cmul_pkg::SAMPLE_W:0] neg_b1;

  cmul_pkg::prod_t         nb1b2;
  cmul_pkg::prod_t         b1a2;
  cmul_pkg::sum_t          sum_re;
  cmul_pkg::sum_t          sum_im;
  cmul_pkg::cplx_t         result_d;
  cmul_pkg::cmul_status_t  status_d;
  cmul_pkg::cplx_t         result_q;
  cmul_pkg::cmul_status_t  status_q;
  logic                    sat_re;
  logic                    sat_im;
  logic                    inexact_re;
  logic                    inexact_im;

  assign ready_o = ~flush_i & (~valid_q | ready_i);
  assign load    = valid_i & ready_o;

  // re = a1*a2 + (-b1)*b2, im = a1*b2 + b1*a2
  assign neg_b1 = -pipe_i.b1;
  assign nb1b2  = neg_b1 * pipe_i.b2;
  assign b1a2   = pipe_i.b1 * pipe_i.a2;
  assign sum_re = pipe_i.a1a2 + nb1b2;
  assign sum_im = pipe_i.a1b2 + b1a2;

  cmul_round_sat round_re_i (
    .sum_i     (sum_re),
    .value_o   (result_d.re),
    .sat_o     (sat_re),
    .inexact_o (inexact_re)
  );

  cmul_round_sat round_im_i (
    .sum_i     (sum_im),
    .value_o   (result_d.im),
    .sat_o     (sat_im),
    .inexact_o (inexact_im)
  );

  assign status_d.sat     = sat_re | sat_im;
  assign status_d.inexact = inexact_re | inexact_im;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // result held under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      result_q <= result_d;
      status_q <= status_d;
    end
  end

  assign result_o = result_q;
  assign status_o = status_q;
  assign valid_o  = valid_q;
  assign busy_o   = valid_q;

endmodule

/* source/complex_mul_add.sv */
`timescale 1ns/100ps

module complex_mul_add (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // input side, operands packed {b2,a2,b1,a1}
  input  cmul_pkg::cmul_operands_t   operands_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  // output side
  output cmul_pkg::cplx_t            result_o,
  output cmul_pkg::cmul_status_t     status_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  // something in flight
  output logic                       busy_o
);

  cmul_pkg::prod_pipe_t prod_pipe;
  logic                 prod_valid;
  logic                 macc_ready;
  logic                 prod_busy;
  logic                 macc_busy;

  assign busy_o = prod_busy | macc_busy;

  // first pass, a1*a2 and a1*b2
  cmul_prod_stage prod_stage_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .operands_i (operands_i),
    .valid_i    (in_valid_i),
    .ready_o    (in_ready_o),
    .pipe_o     (prod_pipe),
    .valid_o    (prod_valid),
    .ready_i    (macc_ready),
    .busy_o     (prod_busy)
  );

  // second pass, multiply-add per part with rounding
  cmul_macc_stage macc_stage_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (flush_i),
    .pipe_i   (prod_pipe),
    .valid_i  (prod_valid),
    .ready_o  (macc_ready),
    .result_o (result_o),
    .status_o (status_o),
    .valid_o  (out_valid_o),
    .ready_i  (out_ready_i),
    .busy_o   (macc_busy)
  );

endmodule

/* sim/tb_cmul_model.svh */
`ifndef TB_CMUL_MODEL_SVH
`define TB_CMUL_MODEL_SVH

function automatic longint to_long(input cmul_pkg::sample_t s);
  to_long = longint'(s);
endfunction

// exact value times 2^-15, nearest with ties to even, then clipped to Q1.15
function automatic void model_part(input longint exact, output cmul_pkg::sample_t value,
                                   output logic sat, output logic inexact);
  longint q;
  longint rem;
  longint half;
  half = longint'(1) <<< (cmul_pkg::FRAC_W - 1);
  // floor division, remainder always in [0, 2^15)
  q   = exact >>> cmul_pkg::FRAC_W;
  rem = exact - (q <<< cmul_pkg::FRAC_W);
  if (rem > half || (rem == half && q[0])) begin
    q = q + 1;
  end
  inexact = (rem != 0);
  sat     = 1'b0;
  if (q > 32767) begin
    q   = 32767;
    sat = 1'b1;
  end else if (q < -32768) begin
    q   = -32768;
    sat = 1'b1;
  end
  value   = cmul_pkg::sample_t'(q);
  inexact = inexact | sat;
endfunction

// (a1 + j b1) * (a2 + j b2)
function automatic void model_cmul(input cmul_pkg::cmul_operands_t ops,
                                   output cmul_pkg::cplx_t res,
                                   output cmul_pkg::cmul_status_t st);
  longint re_exact;
  longint im_exact;
  logic   sat_re;
  logic   sat_im;
  logic   inex_re;
  logic   inex_im;
  re_exact = to_long(ops.a1) * to_long(ops.a2) - to_long(ops.b1) * to_long(ops.b2);
  im_exact = to_long(ops.a1) * to_long(ops.b2) + to_long(ops.b1) * to_long(ops.a2);
  model_part(re_exact, res.re, sat_re, inex_re);
  model_part(im_exact, res.im, sat_im, inex_im);
  st.sat     = sat_re | sat_im;
  st.inexact = inex_re | inex_im;
endfunction

task automatic compare_result(input string name, input cmul_pkg::cplx_t expected,
                              input cmul_pkg::cplx_t actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: expected re=%0d im=%0d, actual re=%0d im=%0d",
             name, expected.re, expected.im, actual.re, actual.im);
    stop_on_failure();
  end
endtask

task automatic compare_status(input string name, input cmul_pkg::cmul_status_t expected,
                              input cmul_pkg::cmul_status_t actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: expected sat=%b inexact=%b, actual sat=%b inexact=%b",
             name, expected.sat, expected.inexact, actual.sat, actual.inexact);
    stop_on_failure();
  end
endtask

task automatic compare_bit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
    stop_on_failure();
  end
endtask

`endif

/* sim/tb_complex_mul_add.sv */
`timescale 1ns/100ps

module tb_complex_mul_add;

  localparam int          CLK_PERIOD    = 20;
  localparam int          RESET_CYCLES  = 16;
  localparam int unsigned SEED          = 32'h8055_1e83;
  localparam int          N_RANDOM      = 300;
  localparam int          N_CORNER      = 9;
  localparam int          N_STALL       = 300;
  localparam int          N_FLUSH       = 3;
  localparam int          N_AFTER_FLUSH = 20;
  localparam int          TOTAL_ITEMS   = N_RANDOM + N_CORNER + N_STALL + N_FLUSH + N_AFTER_FLUSH;
  // worst case per item with input gaps and output stalls
  localparam int          STALL_BOUND   = 40;
  localparam int          MARGIN_CYCLES = 500;
  localparam int          TIMEOUT_NS    =
    (TOTAL_ITEMS * STALL_BOUND + MARGIN_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  logic                     clk_i;
  logic                     reset_i;
  cmul_pkg::cmul_operands_t operands_i;
  logic                     in_valid_i;
  logic                     in_ready_o;
  logic                     flush_i;
  cmul_pkg::cplx_t          result_o;
  cmul_pkg::cmul_status_t   status_o;
  logic                     out_valid_o;
  logic                     out_ready_i;
  logic                     busy_o;

  // 0 always ready, 1 random stalls, 2 held low
  int                       ready_mode;
  string                    test_name;
  cmul_pkg::cplx_t          exp_result_q[$];
  cmul_pkg::cmul_status_t   exp_status_q[$];
  string                    exp_name_q[$];
  logic                     hold_pending;
  cmul_pkg::cplx_t          held_result;

  task automatic stop_on_failure();
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  `include "tb_cmul_model.svh"

  complex_mul_add complex_mul_add_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .operands_i  (operands_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : ready_driver
    out_ready_i <= 1'b1;
    forever begin
      @(posedge clk_i);
      case (ready_mode)
        0:       out_ready_i <= 1'b1;
        1:       out_ready_i <= ($urandom % 4) != 0;
        default: out_ready_i <= 1'b0;
      endcase
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    stop_on_failure();
  end

  // pops on output transfers, pushes on input transfers, checks held outputs
  always @(posedge clk_i) begin : scoreboard
    cmul_pkg::cplx_t        exp_res;
    cmul_pkg::cmul_status_t exp_st;
    string                  name;
    if (reset_i) begin
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        compare_bit("hold valid", 1'b1, out_valid_o);
        compare_result("hold data", held_result, result_o);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_result_q.size() == 0) begin
          $display("an output transfer arrived while no result was expected");
          stop_on_failure();
        end else begin
          exp_res = exp_result_q.pop_front();
          exp_st  = exp_status_q.pop_front();
          name    = exp_name_q.pop_front();
          compare_result(name, exp_res, result_o);
          compare_status(name, exp_st, status_o);
        end
      end
      if (in_valid_i && in_ready_o) begin
        model_cmul(operands_i, exp_res, exp_st);
        exp_result_q.push_back(exp_res);
        exp_status_q.push_back(exp_st);
        exp_name_q.push_back(test_name);
      end
      if (flush_i) begin
        exp_result_q.delete();
        exp_status_q.delete();
        exp_name_q.delete();
      end
      hold_pending = out_valid_o && !out_ready_i && !flush_i;
      held_result  = result_o;
    end
  end

  function automatic cmul_pkg::cmul_operands_t random_operands();
    random_operands = cmul_pkg::cmul_operands_t'({$urandom, $urandom});
  endfunction

  function automatic cmul_pkg::cmul_operands_t make_operands(input int a1, input int b1,
                                                             input int a2, input int b2);
    make_operands.a1 = cmul_pkg::sample_t'(a1);
    make_operands.b1 = cmul_pkg::sample_t'(b1);
    make_operands.a2 = cmul_pkg::sample_t'(a2);
    make_operands.b2 = cmul_pkg::sample_t'(b2);
  endfunction

  task automatic drive_item(input cmul_pkg::cmul_operands_t ops);
    operands_i <= ops;
    in_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    in_valid_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  // queue looked at mid-cycle, after the scoreboard has updated it
  task automatic wait_drain();
    @(negedge clk_i);
    while (exp_result_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic run_corner_cases();
    // -1.0 squared and full-scale parts saturate
    drive_item(make_operands(-32768, 0, -32768, 0));
    drive_item(make_operands(-32768, -32768, -32768, 32767));
    drive_item(make_operands(-32768, -32768, -32768, -32768));
    drive_item(make_operands(32767, 32767, -32768, -32768));
    // dropped bits exactly one half
    drive_item(make_operands(1, 0, 16384, 16384));
    drive_item(make_operands(3, 1, 16384, 0));
    drive_item(make_operands(-1, 0, 16384, 16384));
    drive_item(make_operands(-3, -1, 16384, 0));
    drive_item(make_operands(0, 5, 0, 16384));
  endtask

  task automatic run_flush_test();
    ready_mode <= 2;
    idle_cycles(2);
    // fill both stages
    drive_item(random_operands());
    drive_item(random_operands());
    flush_i    <= 1'b1;
    in_valid_i <= 1'b1;
    operands_i <= random_operands();
    @(posedge clk_i);
    compare_bit("flush: busy before", 1'b1, busy_o);
    compare_bit("flush: in_ready", 1'b0, in_ready_o);
    flush_i    <= 1'b0;
    in_valid_i <= 1'b0;
    ready_mode <= 0;
    @(posedge clk_i);
    compare_bit("flush: busy after", 1'b0, busy_o);
    compare_bit("flush: out_valid after", 1'b0, out_valid_o);
  endtask

  initial begin : stimulus
    void'($urandom(SEED));
    ready_mode   <= 0;
    hold_pending = 1'b0;
    test_name    = "reset";
    reset_i    <= 1'b1;
    flush_i    <= 1'b0;
    in_valid_i <= 1'b0;
    operands_i <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    compare_bit("reset: out_valid", 1'b0, out_valid_o);
    compare_bit("reset: busy", 1'b0, busy_o);
    compare_bit("reset: in_ready", 1'b1, in_ready_o);

    test_name = "random";
    repeat (N_RANDOM) drive_item(random_operands());
    wait_drain();

    test_name = "corner";
    run_corner_cases();
    wait_drain();

    test_name  = "stall";
    ready_mode <= 1;
    repeat (N_STALL) begin
      if ($urandom % 3 == 0) begin
        idle_cycles(1 + $urandom % 3);
      end
      drive_item(random_operands());
    end
    ready_mode <= 0;
    wait_drain();

    test_name = "flush";
    run_flush_test();
    test_name = "after flush";
    repeat (N_AFTER_FLUSH) drive_item(random_operands());
    wait_drain();

    if (busy_o) begin
      $display("the pipeline still holds an item after all results arrived");
      stop_on_failure();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* flist.f */
+incdir+sim
common/cmul_pkg.sv
cmul/cmul_round_sat.sv
cmul/cmul_prod_stage.sv
cmul/cmul_macc_stage.sv
source/complex_mul_add.sv
sim/tb_complex_mul_add.sv

/* Makefile */
# Verilator build and run of the complex multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_complex_mul_add
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  TOP=$(TOP)"
	@echo "  FLIST=$(FLIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR)"
	@echo "  VFLAGS=$(VFLAGS)"

$(SIM_BIN): $(FLIST) $(shell grep -v '^+' $(FLIST)) sim/tb_cmul_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
